// File: cache_config.svh
/* cache geometry macros
   address field widths derived from the geometry */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

`define CACHE_ADDR_WIDTH 16
`define CACHE_DATA_WIDTH 32
`define CACHE_BLOCK_WORDS 4
`define CACHE_SETS 8
`define CACHE_WAYS 2

// byte address = {tag, index, word, byte}
`define CACHE_MASK_WIDTH (`CACHE_DATA_WIDTH / 8)
`define CACHE_BYTE_OFS_WIDTH $clog2(`CACHE_MASK_WIDTH)
`define CACHE_WORD_OFS_WIDTH $clog2(`CACHE_BLOCK_WORDS)
`define CACHE_OFFSET_WIDTH (`CACHE_BYTE_OFS_WIDTH + `CACHE_WORD_OFS_WIDTH)
`define CACHE_INDEX_WIDTH $clog2(`CACHE_SETS)
`define CACHE_TAG_WIDTH (`CACHE_ADDR_WIDTH - `CACHE_OFFSET_WIDTH - `CACHE_INDEX_WIDTH)
`define CACHE_WAY_WIDTH $clog2(`CACHE_WAYS)

`endif

// File: cache_pkg.sv
/* cache types: address fields, tag and data sets, core request */
`include "cache_config.svh"

package cache_pkg;

  typedef logic [`CACHE_ADDR_WIDTH-1:0]  addr_t;
  typedef logic [`CACHE_DATA_WIDTH-1:0]  word_t;
  typedef logic [`CACHE_MASK_WIDTH-1:0]  mask_t;
  typedef logic [`CACHE_INDEX_WIDTH-1:0] index_t;
  typedef logic [`CACHE_TAG_WIDTH-1:0]   tag_t;
  typedef logic [`CACHE_WAY_WIDTH-1:0]   way_t;

  // one tag entry per way
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_info_t;

  // lru names the way to replace next
  typedef struct packed {
    way_t                        lru;
    tag_info_t [`CACHE_WAYS-1:0] way;
  } tag_set_t;

  typedef word_t [`CACHE_BLOCK_WORDS-1:0] block_t;
  typedef block_t [`CACHE_WAYS-1:0]       data_set_t;

  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t data;
    mask_t mask;
  } cache_req_t;

endpackage

// File: cache_sync_ram.sv
/* single-port synchronous memory
   registered read that holds its value, per-bit write mask */
`include "cache_config.svh"

module cache_sync_ram #(
  parameter type entry_t = logic,
  parameter int  ELS     = `CACHE_SETS
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              v_i,
  input  logic              w_i,
  input  cache_pkg::index_t addr_i,
  input  entry_t            data_i,
  input  entry_t            w_mask_i,
  output entry_t            data_o
);

  entry_t mem [ELS];

  // a write leaves data_o on the last read
  always_ff @(posedge clk_i) begin
    if (v_i && w_i) begin
      mem[addr_i] <= (mem[addr_i] & ~w_mask_i) | (data_i & w_mask_i);
    end else if (v_i) begin
      data_o <= mem[addr_i];
    end
  end

  a_addr_known: assert property (
    @(posedge clk_i) disable iff (reset_i)
    v_i |-> !$isunknown(addr_i)
  );

endmodule

// File: cache_lookup.sv
/* first pipeline stage of the data cache
   tag and data memories and the arbitration of their single port */
`include "cache_config.svh"

module cache_lookup (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  v_i,
  output logic                  ready_o,
  input  cache_pkg::addr_t      addr_i,
  input  cache_pkg::word_t      data_i,
  input  cache_pkg::mask_t      mask_i,
  input  logic                  we_i,
  output cache_pkg::cache_req_t tl_req_o,
  output cache_pkg::tag_set_t   tl_tags_o,
  output cache_pkg::data_set_t  tl_data_o,
  output logic                  tl_v_o,
  input  logic                  tv_take_i,
  input  logic                  rsp_w_i,
  input  cache_pkg::index_t     rsp_index_i,
  input  cache_pkg::tag_set_t   rsp_tags_i,
  input  cache_pkg::tag_set_t   rsp_tag_mask_i,
  input  cache_pkg::data_set_t  rsp_data_i,
  input  cache_pkg::data_set_t  rsp_data_mask_i,
  input  logic                  miss_w_i,
  input  cache_pkg::index_t     miss_index_i,
  input  cache_pkg::tag_info_t  miss_tags_i,
  input  cache_pkg::block_t     miss_data_i,
  input  cache_pkg::way_t       miss_way_i
);

  logic                        tl_v_r;
  logic                        fresh_r;
  cache_pkg::cache_req_t       tl_req_r;
  logic [`CACHE_INDEX_WIDTH:0] init_cnt_r;
  logic                        init_w;
  logic                        any_w;
  logic                        rd;
  cache_pkg::index_t           tl_index;
  cache_pkg::index_t           ram_addr;
  cache_pkg::tag_set_t         tag_wdata;
  cache_pkg::tag_set_t         tag_wmask;
  cache_pkg::data_set_t        data_wdata;
  cache_pkg::data_set_t        data_wmask;
  cache_pkg::tag_set_t         miss_tag_set;
  cache_pkg::tag_set_t         miss_tag_mask;
  cache_pkg::data_set_t        miss_data_set;
  cache_pkg::data_set_t        miss_data_mask;

  // tags are swept invalid after reset, one set per cycle
  assign init_w   = ~init_cnt_r[`CACHE_INDEX_WIDTH];
  assign any_w    = init_w | rsp_w_i | miss_w_i;
  assign tl_index = tl_req_r.addr[`CACHE_OFFSET_WIDTH +: `CACHE_INDEX_WIDTH];

  // first read and re-read of a held item are the same access
  assign rd       = tl_v_r & ~fresh_r & ~any_w;
  assign tl_v_o   = tl_v_r & fresh_r & ~any_w;
  assign ready_o  = ~any_w & (~tl_v_r | (fresh_r & tv_take_i));
  assign tl_req_o = tl_req_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tl_v_r     <= 1'b0;
      fresh_r    <= 1'b0;
      init_cnt_r <= '0;
    end else begin
      if (init_w) begin
        init_cnt_r <= init_cnt_r + 1'b1;
      end
      if (ready_o) begin
        tl_v_r <= v_i;
      end
      // any write may touch the held set
      if (ready_o || any_w) begin
        fresh_r <= 1'b0;
      end else if (rd) begin
        fresh_r <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o && v_i) begin
      tl_req_r <= '{we: we_i, addr: addr_i, data: data_i, mask: mask_i};
    end
  end

  // fill writes only the chosen way
  always_comb begin
    miss_tag_set  = '0;
    miss_tag_mask = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      miss_tag_set.way[w]  = miss_tags_i;
      miss_tag_mask.way[w] = (miss_way_i == w) ? '1 : '0;
      miss_data_set[w]     = miss_data_i;
      miss_data_mask[w]    = (miss_way_i == w) ? '1 : '0;
    end
  end

  assign ram_addr   = init_w   ? init_cnt_r[`CACHE_INDEX_WIDTH-1:0] :
                      miss_w_i ? miss_index_i :
                      rsp_w_i  ? rsp_index_i : tl_index;
  assign tag_wdata  = init_w ? '0 : (miss_w_i ? miss_tag_set : rsp_tags_i);
  assign tag_wmask  = init_w ? '1 : (miss_w_i ? miss_tag_mask : rsp_tag_mask_i);
  assign data_wdata = miss_w_i ? miss_data_set : rsp_data_i;
  assign data_wmask = init_w ? '0 : (miss_w_i ? miss_data_mask : rsp_data_mask_i);

  cache_sync_ram #(
    .entry_t(cache_pkg::tag_set_t),
    .ELS    (`CACHE_SETS)
  ) u_tag_ram (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (any_w | rd),
    .w_i     (any_w),
    .addr_i  (ram_addr),
    .data_i  (tag_wdata),
    .w_mask_i(tag_wmask),
    .data_o  (tl_tags_o)
  );

  cache_sync_ram #(
    .entry_t(cache_pkg::data_set_t),
    .ELS    (`CACHE_SETS)
  ) u_data_ram (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (any_w | rd),
    .w_i     (any_w),
    .addr_i  (ram_addr),
    .data_i  (data_wdata),
    .w_mask_i(data_wmask),
    .data_o  (tl_data_o)
  );

  // response and miss engine never write together
  a_one_writer: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(rsp_w_i && miss_w_i)
  );

endmodule

// File: cache_miss.sv
/* miss engine: victim choice, dirty write-back and block fill
   over the block-transfer memory port */
`include "cache_config.svh"

module cache_miss (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 miss_start_i,
  input  cache_pkg::addr_t     miss_addr_i,
  input  cache_pkg::tag_set_t  miss_tags_i,
  input  cache_pkg::data_set_t miss_data_i,
  output logic                 dma_pkt_v_o,
  output logic                 dma_pkt_write_o,
  output cache_pkg::addr_t     dma_pkt_addr_o,
  input  logic                 dma_pkt_yumi_i,
  input  cache_pkg::word_t     dma_data_i,
  input  logic                 dma_data_v_i,
  output logic                 dma_data_ready_o,
  output cache_pkg::word_t     dma_data_o,
  output logic                 dma_data_v_o,
  input  logic                 dma_data_yumi_i,
  output logic                 miss_w_o,
  output cache_pkg::index_t    miss_index_o,
  output cache_pkg::tag_info_t miss_tags_o,
  output cache_pkg::block_t    miss_data_o,
  output cache_pkg::way_t      miss_way_o,
  output logic                 fill_done_o,
  output cache_pkg::way_t      fill_way_o,
  output cache_pkg::block_t    fill_block_o
);

  typedef enum logic [2:0] {
    e_idle,
    e_wb_pkt,
    e_wb_data,
    e_rd_pkt,
    e_rd_data,
    e_fill,
    e_done
  } state_e;

  state_e                           state_r;
  cache_pkg::addr_t                 addr_r;
  cache_pkg::tag_t                  vtag_r;
  cache_pkg::way_t                  way_r;
  cache_pkg::block_t                buf_r;
  logic [`CACHE_WORD_OFS_WIDTH:0]   cnt_r;
  logic [`CACHE_WORD_OFS_WIDTH-1:0] word;
  cache_pkg::way_t                  victim;
  logic                             victim_dirty;
  cache_pkg::index_t                index;
  logic                             last;
  logic                             beat;

  // first invalid way, else the lru way
  always_comb begin
    victim = miss_tags_i.lru;
    for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
      if (!miss_tags_i.way[w].valid) begin
        victim = cache_pkg::way_t'(w);
      end
    end
  end

  assign victim_dirty = miss_tags_i.way[victim].valid & miss_tags_i.way[victim].dirty;
  assign index = addr_r[`CACHE_OFFSET_WIDTH +: `CACHE_INDEX_WIDTH];
  assign word  = cnt_r[`CACHE_WORD_OFS_WIDTH-1:0];
  assign last  = (cnt_r == `CACHE_BLOCK_WORDS - 1);
  assign beat  = (state_r == e_wb_data && dma_data_yumi_i)
               | (state_r == e_rd_data && dma_data_v_i);

  assign dma_pkt_v_o      = (state_r == e_wb_pkt) | (state_r == e_rd_pkt);
  assign dma_pkt_write_o  = (state_r == e_wb_pkt);
  assign dma_pkt_addr_o   = dma_pkt_write_o
                          ? {vtag_r, index, {`CACHE_OFFSET_WIDTH{1'b0}}}
                          : {addr_r[`CACHE_ADDR_WIDTH-1:`CACHE_OFFSET_WIDTH],
                             {`CACHE_OFFSET_WIDTH{1'b0}}};
  assign dma_data_v_o     = (state_r == e_wb_data);
  assign dma_data_o       = buf_r[word];
  assign dma_data_ready_o = (state_r == e_rd_data);

  assign miss_w_o     = (state_r == e_fill);
  assign miss_index_o = index;
  assign miss_tags_o  = '{valid: 1'b1, dirty: 1'b0,
                          tag: addr_r[`CACHE_ADDR_WIDTH-1 -: `CACHE_TAG_WIDTH]};
  assign miss_data_o  = buf_r;
  assign miss_way_o   = way_r;
  assign fill_done_o  = (state_r == e_done);
  assign fill_way_o   = way_r;
  assign fill_block_o = buf_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
      cnt_r   <= '0;
    end else begin
      if (beat) begin
        cnt_r <= last ? '0 : cnt_r + 1'b1;
      end
      case (state_r)
        e_idle: begin
          if (miss_start_i) begin
            state_r <= victim_dirty ? e_wb_pkt : e_rd_pkt;
          end
        end
        e_wb_pkt: begin
          if (dma_pkt_yumi_i) begin
            state_r <= e_wb_data;
          end
        end
        e_wb_data: begin
          if (beat && last) begin
            state_r <= e_rd_pkt;
          end
        end
        e_rd_pkt: begin
          if (dma_pkt_yumi_i) begin
            state_r <= e_rd_data;
          end
        end
        e_rd_data: begin
          if (beat && last) begin
            state_r <= e_fill;
          end
        end
        e_fill: state_r <= e_done;
        default: state_r <= e_idle;
      endcase
    end
  end

  // one buffer holds the victim block, then the fill words
  always_ff @(posedge clk_i) begin
    if (state_r == e_idle && miss_start_i) begin
      addr_r <= miss_addr_i;
      way_r  <= victim;
      vtag_r <= miss_tags_i.way[victim].tag;
      buf_r  <= miss_data_i[victim];
    end else if (state_r == e_rd_data && dma_data_v_i) begin
      buf_r[word] <= dma_data_i;
    end
  end

  a_cnt_range: assert property (
    @(posedge clk_i) disable iff (reset_i)
    cnt_r < `CACHE_BLOCK_WORDS
  );

endmodule

// File: cache_response.sv
/* second pipeline stage of the data cache
   hit detection, load data, store merge and lru/dirty update */
`include "cache_config.svh"

module cache_response (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  cache_pkg::cache_req_t tl_req_i,
  input  cache_pkg::tag_set_t   tl_tags_i,
  input  cache_pkg::data_set_t  tl_data_i,
  input  logic                  tl_v_i,
  output logic                  tv_take_o,
  output logic                  v_o,
  output cache_pkg::word_t      data_o,
  input  logic                  yumi_i,
  output logic                  rsp_w_o,
  output cache_pkg::index_t     rsp_index_o,
  output cache_pkg::tag_set_t   rsp_tags_o,
  output cache_pkg::tag_set_t   rsp_tag_mask_o,
  output cache_pkg::data_set_t  rsp_data_o,
  output cache_pkg::data_set_t  rsp_data_mask_o,
  output logic                  miss_start_o,
  output cache_pkg::addr_t      miss_addr_o,
  output cache_pkg::tag_set_t   miss_tags_o,
  output cache_pkg::data_set_t  miss_data_o,
  input  logic                  fill_done_i,
  input  cache_pkg::way_t       fill_way_i,
  input  cache_pkg::block_t     fill_block_i
);

  logic                             tv_v_r;
  logic                             miss_busy_r;
  cache_pkg::cache_req_t            tv_req_r;
  cache_pkg::tag_set_t              tv_tags_r;
  cache_pkg::data_set_t             tv_data_r;
  cache_pkg::tag_t                  tv_tag;
  logic [`CACHE_WORD_OFS_WIDTH-1:0] tv_word;
  logic [`CACHE_WAYS-1:0]           hit;
  logic                             hit_found;
  cache_pkg::way_t                  hit_way;
  logic                             accept;

  assign tv_tag  = tv_req_r.addr[`CACHE_ADDR_WIDTH-1 -: `CACHE_TAG_WIDTH];
  assign tv_word = tv_req_r.addr[`CACHE_BYTE_OFS_WIDTH +: `CACHE_WORD_OFS_WIDTH];

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      hit[w] = tv_tags_r.way[w].valid & (tv_tags_r.way[w].tag == tv_tag);
      if (hit[w]) begin
        hit_way = cache_pkg::way_t'(w);
      end
    end
  end

  assign hit_found    = |hit;
  assign v_o          = tv_v_r & hit_found;
  assign accept       = v_o & yumi_i;
  assign tv_take_o    = ~tv_v_r | accept;
  assign miss_start_o = tv_v_r & ~hit_found & ~miss_busy_r;
  assign data_o       = tv_req_r.we ? '0 : tv_data_r[hit_way][tv_word];

  assign miss_addr_o = tv_req_r.addr;
  assign miss_tags_o = tv_tags_r;
  assign miss_data_o = tv_data_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tv_v_r      <= 1'b0;
      miss_busy_r <= 1'b0;
    end else begin
      if (tv_take_o) begin
        tv_v_r <= tl_v_i;
      end
      if (fill_done_i) begin
        miss_busy_r <= 1'b0;
      end else if (miss_start_o) begin
        miss_busy_r <= 1'b1;
      end
    end
  end

  // the filled way is patched in, so the item retires as a hit
  always_ff @(posedge clk_i) begin
    if (tv_take_o && tl_v_i) begin
      tv_req_r  <= tl_req_i;
      tv_tags_r <= tl_tags_i;
      tv_data_r <= tl_data_i;
    end else if (fill_done_i) begin
      tv_tags_r.way[fill_way_i] <= '{valid: 1'b1, dirty: 1'b0, tag: tv_tag};
      tv_data_r[fill_way_i]     <= fill_block_i;
    end
  end

  assign rsp_w_o     = accept;
  assign rsp_index_o = tv_req_r.addr[`CACHE_OFFSET_WIDTH +: `CACHE_INDEX_WIDTH];
  assign rsp_data_o  = {(`CACHE_WAYS * `CACHE_BLOCK_WORDS){tv_req_r.data}};

  // lru points at the way not hit; stores also mark the line dirty
  always_comb begin
    rsp_tags_o                         = tv_tags_r;
    rsp_tag_mask_o                     = '0;
    rsp_tags_o.lru                     = ~hit_way;
    rsp_tag_mask_o.lru                 = '1;
    rsp_tags_o.way[hit_way].dirty      = 1'b1;
    rsp_tag_mask_o.way[hit_way].dirty  = tv_req_r.we;
    rsp_data_mask_o                    = '0;
    for (int b = 0; b < `CACHE_MASK_WIDTH; b++) begin
      rsp_data_mask_o[hit_way][tv_word][8*b +: 8] = {8{tv_req_r.we & tv_req_r.mask[b]}};
    end
  end

  a_single_hit: assert property (
    @(posedge clk_i) disable iff (reset_i)
    tv_v_r |-> $onehot0(hit)
  );

endmodule

// File: cache_top.sv
/* data cache top level
   lookup stage, response stage and miss engine */
module cache_top (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  v_i,
  output logic                  ready_o,
  input  cache_pkg::addr_t      addr_i,
  input  cache_pkg::word_t      data_i,
  input  cache_pkg::mask_t      mask_i,
  input  logic                  we_i,
  output logic                  v_o,
  output cache_pkg::word_t      data_o,
  input  logic                  yumi_i,
  output logic                  dma_pkt_v_o,
  output logic                  dma_pkt_write_o,
  output cache_pkg::addr_t      dma_pkt_addr_o,
  input  logic                  dma_pkt_yumi_i,
  input  cache_pkg::word_t      dma_data_i,
  input  logic                  dma_data_v_i,
  output logic                  dma_data_ready_o,
  output cache_pkg::word_t      dma_data_o,
  output logic                  dma_data_v_o,
  input  logic                  dma_data_yumi_i
);

  cache_pkg::cache_req_t tl_req;
  cache_pkg::tag_set_t   tl_tags;
  cache_pkg::data_set_t  tl_data;
  logic                  tl_v;
  logic                  tv_take;
  logic                  rsp_w;
  cache_pkg::index_t     rsp_index;
  cache_pkg::tag_set_t   rsp_tags;
  cache_pkg::tag_set_t   rsp_tag_mask;
  cache_pkg::data_set_t  rsp_data;
  cache_pkg::data_set_t  rsp_data_mask;
  logic                  miss_start;
  cache_pkg::addr_t      miss_addr;
  cache_pkg::tag_set_t   tv_tags;
  cache_pkg::data_set_t  tv_data;
  logic                  miss_w;
  cache_pkg::index_t     miss_index;
  cache_pkg::tag_info_t  miss_tags;
  cache_pkg::block_t     miss_block;
  cache_pkg::way_t       miss_way;
  logic                  fill_done;
  cache_pkg::way_t       fill_way;
  cache_pkg::block_t     fill_block;

  cache_lookup u_lookup (
    .*,
    .tl_req_o       (tl_req),
    .tl_tags_o      (tl_tags),
    .tl_data_o      (tl_data),
    .tl_v_o         (tl_v),
    .tv_take_i      (tv_take),
    .rsp_w_i        (rsp_w),
    .rsp_index_i    (rsp_index),
    .rsp_tags_i     (rsp_tags),
    .rsp_tag_mask_i (rsp_tag_mask),
    .rsp_data_i     (rsp_data),
    .rsp_data_mask_i(rsp_data_mask),
    .miss_w_i       (miss_w),
    .miss_index_i   (miss_index),
    .miss_tags_i    (miss_tags),
    .miss_data_i    (miss_block),
    .miss_way_i     (miss_way)
  );

  cache_response u_response (
    .*,
    .tl_req_i       (tl_req),
    .tl_tags_i      (tl_tags),
    .tl_data_i      (tl_data),
    .tl_v_i         (tl_v),
    .tv_take_o      (tv_take),
    .rsp_w_o        (rsp_w),
    .rsp_index_o    (rsp_index),
    .rsp_tags_o     (rsp_tags),
    .rsp_tag_mask_o (rsp_tag_mask),
    .rsp_data_o     (rsp_data),
    .rsp_data_mask_o(rsp_data_mask),
    .miss_start_o   (miss_start),
    .miss_addr_o    (miss_addr),
    .miss_tags_o    (tv_tags),
    .miss_data_o    (tv_data),
    .fill_done_i    (fill_done),
    .fill_way_i     (fill_way),
    .fill_block_i   (fill_block)
  );

  cache_miss u_miss (
    .*,
    .miss_start_i(miss_start),
    .miss_addr_i (miss_addr),
    .miss_tags_i (tv_tags),
    .miss_data_i (tv_data),
    .miss_w_o    (miss_w),
    .miss_index_o(miss_index),
    .miss_tags_o (miss_tags),
    .miss_data_o (miss_block),
    .miss_way_o  (miss_way),
    .fill_done_o (fill_done),
    .fill_way_o  (fill_way),
    .fill_block_o(fill_block)
  );

endmodule

// File: tb_clock_gen.sv
/* free-running testbench clock */
module tb_clock_gen #(
  parameter int PERIOD = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule

// File: cache_tb.sv
/* data cache testbench
   core stimulus, block-transfer memory model, reference word array
   and the checks on responses and packets */
`include "cache_config.svh"

module cache_tb;

  localparam int LIMIT = 200;
  localparam int WORDS = 1 << (`CACHE_ADDR_WIDTH - `CACHE_BYTE_OFS_WIDTH);
  localparam int BLOCK_BYTES = `CACHE_BLOCK_WORDS * `CACHE_MASK_WIDTH;

  logic                  clk_i;
  logic                  reset_i;
  logic                  v_i;
  logic                  ready_o;
  cache_pkg::addr_t      addr_i;
  cache_pkg::word_t      data_i;
  cache_pkg::mask_t      mask_i;
  logic                  we_i;
  logic                  v_o;
  cache_pkg::word_t      data_o;
  logic                  yumi_i;
  logic                  dma_pkt_v_o;
  logic                  dma_pkt_write_o;
  cache_pkg::addr_t      dma_pkt_addr_o;
  logic                  dma_pkt_yumi_i = 1'b0;
  cache_pkg::word_t      dma_data_i = '0;
  logic                  dma_data_v_i = 1'b0;
  logic                  dma_data_ready_o;
  cache_pkg::word_t      dma_data_o;
  logic                  dma_data_v_o;
  logic                  dma_data_yumi_i = 1'b0;

  cache_pkg::word_t           mem [WORDS];
  cache_pkg::word_t           ref_mem [WORDS];
  logic [`CACHE_ADDR_WIDTH:0] pkt_log [$];
  logic [31:0]                rng = 32'd15;
  logic                       started = 1'b0;
  int                         blk_base;
  int                         blk_beat;
  int                         data_errs = 0;
  int                         proto_errs = 0;
  int                         timeouts = 0;

  tb_clock_gen #(.PERIOD(100)) u_clk (.clk_o(clk_i));

  cache_top u_dut (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic int draw_delay();
    rng = xorshift(rng);
    return int'(rng % 3);
  endfunction

  function automatic logic [`CACHE_ADDR_WIDTH:0] read_pkt(input cache_pkg::addr_t a);
    return {1'b0, a & ~cache_pkg::addr_t'(BLOCK_BYTES - 1)};
  endfunction

  function automatic logic [`CACHE_ADDR_WIDTH:0] write_pkt(input cache_pkg::addr_t a);
    return {1'b1, a & ~cache_pkg::addr_t'(BLOCK_BYTES - 1)};
  endfunction

  // memory model takes each packet one cycle after it shows up
  always @(posedge clk_i) begin
    if (reset_i) begin
      dma_pkt_yumi_i  <= 1'b0;
      dma_data_v_i    <= 1'b0;
      dma_data_yumi_i <= 1'b0;
    end else begin
      dma_data_yumi_i <= 1'b1;
      if (dma_pkt_v_o && dma_pkt_yumi_i) begin
        dma_pkt_yumi_i <= 1'b0;
        pkt_log.push_back({dma_pkt_write_o, dma_pkt_addr_o});
        blk_base = int'(dma_pkt_addr_o) >> `CACHE_BYTE_OFS_WIDTH;
        blk_beat = 0;
        if (!dma_pkt_write_o) begin
          dma_data_v_i <= 1'b1;
          dma_data_i   <= mem[blk_base];
        end
      end else if (dma_pkt_v_o) begin
        dma_pkt_yumi_i <= 1'b1;
      end
      if (dma_data_v_i && dma_data_ready_o) begin
        blk_beat++;
        if (blk_beat == `CACHE_BLOCK_WORDS) begin
          dma_data_v_i <= 1'b0;
        end else begin
          dma_data_i <= mem[blk_base + blk_beat];
        end
      end
      // write-back words must match what the core stored
      if (dma_data_v_o && dma_data_yumi_i) begin
        assert (dma_data_o === ref_mem[blk_base + blk_beat]) else begin
          data_errs++;
          $display("ERROR %0t: write-back word %0d is %h, expected %h", $time, blk_beat,
                   dma_data_o, ref_mem[blk_base + blk_beat]);
        end
        mem[blk_base + blk_beat] = dma_data_o;
        blk_beat++;
      end
    end
  end

  a_quiet_start: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !started |-> !v_o && !dma_pkt_v_o && !dma_data_v_o && !dma_data_ready_o
  ) else begin
    proto_errs++;
    $display("ERROR %0t: output raised before the first request", $time);
  end

  a_rsp_hold: assert property (
    @(posedge clk_i) disable iff (reset_i)
    v_o && !yumi_i |=> v_o && $stable(data_o)
  ) else begin
    proto_errs++;
    $display("ERROR %0t: response changed while yumi_i was low", $time);
  end

  task automatic report_hang(input string what);
    timeouts++;
    $display("timeout: %s, gave up at time %0t", what, $time);
  endtask

  task automatic drive_req(input logic we, input cache_pkg::addr_t a,
                           input cache_pkg::word_t d, input cache_pkg::mask_t m);
    repeat (draw_delay()) @(posedge clk_i);
    started = 1'b1;
    // the reference array takes the store in byte-mask order
    if (we) begin
      for (int b = 0; b < `CACHE_MASK_WIDTH; b++) begin
        if (m[b]) begin
          ref_mem[a >> 2][8*b +: 8] = d[8*b +: 8];
        end
      end
    end
    v_i    <= 1'b1;
    we_i   <= we;
    addr_i <= a;
    data_i <= d;
    mask_i <= m;
  endtask

  task automatic wait_accept();
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!ready_o && n < LIMIT && timeouts == 0);
    if (!ready_o) begin
      report_hang("the cache never accepted a request");
    end
    v_i <= 1'b0;
  endtask

  task automatic wait_valid();
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!v_o && n < LIMIT && timeouts == 0);
    if (!v_o) begin
      report_hang("no response came back");
    end
  endtask

  task automatic take_rsp(input cache_pkg::word_t expected, input string what);
    cache_pkg::word_t got;
    wait_valid();
    if (v_o) begin
      repeat (draw_delay()) @(posedge clk_i);
      yumi_i <= 1'b1;
      @(posedge clk_i);
      got = data_o;
      yumi_i <= 1'b0;
      assert (got === expected) else begin
        data_errs++;
        $display("ERROR %0t: %s returned %h, expected %h", $time, what, got, expected);
      end
    end
  endtask

  task automatic load(input cache_pkg::addr_t a, input string what);
    drive_req(1'b0, a, '0, '0);
    wait_accept();
    take_rsp(ref_mem[a >> 2], what);
  endtask

  task automatic store(input cache_pkg::addr_t a, input cache_pkg::word_t d,
                       input cache_pkg::mask_t m, input string what);
    drive_req(1'b1, a, d, m);
    wait_accept();
    take_rsp('0, what);
  endtask

  task automatic check_log(input int mark, input int count,
                           input logic [`CACHE_ADDR_WIDTH:0] first,
                           input logic [`CACHE_ADDR_WIDTH:0] second, input string what);
    assert (pkt_log.size() - mark == count) else begin
      data_errs++;
      $display("ERROR %0t: %s gave %0d packets, expected %0d", $time, what,
               pkt_log.size() - mark, count);
    end
    if (count > 0 && pkt_log.size() > mark) begin
      assert (pkt_log[mark] == first) else begin
        data_errs++;
        $display("ERROR %0t: %s first packet %h, expected %h", $time, what,
                 pkt_log[mark], first);
      end
    end
    if (count > 1 && pkt_log.size() > mark + 1) begin
      assert (pkt_log[mark + 1] == second) else begin
        data_errs++;
        $display("ERROR %0t: %s second packet %h, expected %h", $time, what,
                 pkt_log[mark + 1], second);
      end
    end
  endtask

  initial begin
    int mark;
    reset_i <= 1'b1;
    v_i     <= 1'b0;
    we_i    <= 1'b0;
    addr_i  <= '0;
    data_i  <= '0;
    mask_i  <= '0;
    yumi_i  <= 1'b0;
    for (int i = 0; i < WORDS; i++) begin
      mem[i]     = {16'hA5A5, cache_pkg::addr_t'(i * `CACHE_MASK_WIDTH)};
      ref_mem[i] = mem[i];
    end
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    repeat (12) @(posedge clk_i);

    mark = pkt_log.size();
    load(16'h0104, "load miss");
    check_log(mark, 1, read_pkt(16'h0104), '0, "load miss");
    mark = pkt_log.size();
    store(16'h0108, 32'h11223344, 4'b0101, "partial store");
    load(16'h0108, "load after partial store");
    check_log(mark, 0, '0, '0, "store and load hit");

    // set 2 with tags A, B and C
    load(16'h0820, "load A");
    load(16'h08A0, "load B");
    load(16'h0820, "load A again");
    mark = pkt_log.size();
    load(16'h0920, "load C");
    check_log(mark, 1, read_pkt(16'h0920), '0, "load C");
    mark = pkt_log.size();
    load(16'h0820, "reload A");
    check_log(mark, 0, '0, '0, "reload A");

    // dirty D in set 5 is the lru victim when F misses
    store(16'h1050, 32'hCAFE0001, 4'hF, "store D");
    load(16'h10D0, "load E");
    mark = pkt_log.size();
    load(16'h1150, "load F");
    check_log(mark, 2, write_pkt(16'h1050), read_pkt(16'h1150), "dirty eviction");
    load(16'h1050, "reload D");

    // first response held back while a second request sits behind it
    drive_req(1'b0, 16'h0104, '0, '0);
    wait_accept();
    wait_valid();
    drive_req(1'b0, 16'h0108, '0, '0);
    wait_accept();
    repeat (8) begin
      @(posedge clk_i);
      assert (!ready_o) else begin
        proto_errs++;
        $display("ERROR %0t: ready_o high behind a stalled response", $time);
      end
    end
    take_rsp(ref_mem[16'h0104 >> 2], "stalled first load");
    take_rsp(ref_mem[16'h0108 >> 2], "stalled second load");

    $display("errors: %0d data, %0d protocol, %0d timeouts", data_errs, proto_errs, timeouts);
    if (data_errs + proto_errs + timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+.
cache_pkg.sv
cache_sync_ram.sv
cache_lookup.sv
cache_miss.sv
cache_response.sv
cache_top.sv
tb_clock_gen.sv
cache_tb.sv
